// ==== tb.f ====
+incdir+verilog
verilog/drbe_types_pkg.sv
verilog/drbe_ctrl_pkg.sv
verilog/lc_write_ctrl.sv
verilog/lc_read_seq.sv
verilog/lc_sample_store.sv
verilog/local_controller.sv
verilog/lc_ring_top.sv
testbench/lc_clock_gen.sv
testbench/lc_ring_tb.sv

// ==== testbench/lc_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module lc_clock_gen #(
	parameter int PERIOD_NS    = 40,
	parameter int RESET_CYCLES = 16
) (
	output logic CLK,
	output logic rst_n
);

	initial begin
		CLK = 1'b0;
		forever #(PERIOD_NS / 2) CLK = ~CLK;
	end

	// reset released on a rising edge after RESET_CYCLES periods
	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge CLK);
		rst_n <= 1'b1;
	end

endmodule

`default_nettype wire

// ==== testbench/lc_ring_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "drbe_cfg.svh"

module lc_ring_tb import drbe_types_pkg::*; ();

	logic                 CLK;
	logic                 rst_n;
	logic                 boot_up;
	logic [`LC_COUNT-1:0] cfg_load;
	lc_cfg_t              cfg_in [`LC_COUNT];
	logic                 scenario_update;
	logic                 write_go;
	sample_t              sample_in;
	logic                 start;
	packet_t              packet_out [`LC_COUNT];
	wire                  write_done;
	wire                  read_done;

	// contents of the vector file
	lc_cfg_t file_cfg [`LC_COUNT];
	lc_cfg_t late_cfg;
	int      late_idx;
	sample_t samples [`LC_COUNT*`LC_DEPTH];

	// reference copy of each controller's configuration register
	lc_cfg_t model_cfg [`LC_COUNT];
	logic    model_valid [`LC_COUNT];

	packet_t exp_pkt [$];
	int      exp_idx [$];
	packet_t got_pkt [$];
	int      got_idx [$];

	int cycle = 0;
	int error_count = 0;
	int timeout_count = 0;
	int wd_count = 0;
	int wd_cycle = 0;
	int rd_count = 0;
	int rd_cycle = 0;
	int last_pkt_cycle = 0;
	int last_drive_cycle = 0;

	lc_clock_gen #(.PERIOD_NS(40), .RESET_CYCLES(16)) u_clk (.CLK(CLK), .rst_n(rst_n));

	lc_ring_top DUT (
		.CLK             (CLK),
		.rst_n           (rst_n),
		.boot_up         (boot_up),
		.cfg_load        (cfg_load),
		.cfg_in          (cfg_in),
		.scenario_update (scenario_update),
		.write_go        (write_go),
		.sample_in       (sample_in),
		.start           (start),
		.packet_out      (packet_out),
		.write_done      (write_done),
		.read_done       (read_done)
	);

	////////////////////////////////////////////////////////////
	// monitor, samples on the falling edge
	////////////////////////////////////////////////////////////

	// period count, moves on the falling edge so it is steady at rising edges
	always @(negedge CLK) cycle <= cycle + 1;

	always @(negedge CLK) begin
		if (rst_n) begin
			for (int i = 0; i < `LC_COUNT; i++) begin
				if (packet_out[i].kind != PKT_IDLE) begin
					got_pkt.push_back(packet_out[i]);
					got_idx.push_back(i);
					last_pkt_cycle = cycle;
				end
			end
			if (write_done) begin
				wd_count++;
				wd_cycle = cycle;
			end
			if (read_done) begin
				rd_count++;
				rd_cycle = cycle;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// checks and run control
	////////////////////////////////////////////////////////////

	task automatic end_run();
		$display("errors: %0d, timeouts: %0d", error_count, timeout_count);
		if (error_count == 0 && timeout_count == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	endtask

	task automatic check_packet(string name, packet_t got, packet_t exp);
		if (got !== exp) begin
			error_count++;
			$display("Error at %0t: %s got %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_kind(string name, pkt_kind_e got, pkt_kind_e exp);
		if (got !== exp) begin
			error_count++;
			$display("Error at %0t: %s got %0d, expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic check_count(string name, int got, int exp);
		if (got != exp) begin
			error_count++;
			$display("Error at %0t: %s got %0d, expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic wait_reset();
		int n;
		n = 0;
		while (!rst_n && n < 100) begin
			@(posedge CLK);
			n++;
		end
		if (!rst_n) begin
			timeout_count++;
			$display("reset was never released");
		end
	endtask

	task automatic wait_done(bit on_read, int target, int limit);
		int n;
		n = 0;
		while (((on_read ? rd_count : wd_count) < target) && n < limit) begin
			@(posedge CLK);
			n++;
		end
		if ((on_read ? rd_count : wd_count) < target) begin
			timeout_count++;
			$display("%s did not pulse within %0d cycles",
				on_read ? "read_done" : "write_done", limit);
		end
	endtask

	////////////////////////////////////////////////////////////
	// stimulus
	////////////////////////////////////////////////////////////

	function automatic lc_cfg_t make_cfg(int off, int dst, int pfe, int pfs, int pfp, int pfd);
		lc_cfg_t c;
		c.rd_offset = addr_t'(off);
		c.rd_dest   = dest_t'(dst);
		c.pf_en     = pfe[0];
		c.pf_start  = addr_t'(pfs);
		c.pf_stop   = addr_t'(pfp);
		c.pf_dest   = dest_t'(pfd);
		return c;
	endfunction

	task automatic read_vectors();
		int    fd;
		int    n_cfg;
		int    n_smp;
		int    cnt;
		int    f [7];
		string line;
		n_cfg = 0;
		n_smp = 0;
		fd = $fopen("testbench/lc_ring_vectors.txt", "r");
		if (fd == 0) begin
			error_count++;
			$display("could not open testbench/lc_ring_vectors.txt");
		end else begin
			while ($fgets(line, fd) != 0) begin
				if (line.len() > 0 && line.getc(0) != "#" && line.getc(0) != "\n") begin
					if (n_cfg < `LC_COUNT) begin
						cnt = $sscanf(line, "%h %h %h %h %h %h",
							f[0], f[1], f[2], f[3], f[4], f[5]);
						file_cfg[n_cfg] = make_cfg(f[0], f[1], f[2], f[3], f[4], f[5]);
						n_cfg++;
						cnt = cnt - 6;
					end else if (n_cfg == `LC_COUNT) begin
						cnt = $sscanf(line, "%h %h %h %h %h %h %h",
							f[6], f[0], f[1], f[2], f[3], f[4], f[5]);
						late_idx = f[6];
						late_cfg = make_cfg(f[0], f[1], f[2], f[3], f[4], f[5]);
						n_cfg++;
						cnt = cnt - 7;
					end else begin
						cnt = $sscanf(line, "%h %h", f[0], f[1]);
						if (n_smp < `LC_COUNT*`LC_DEPTH - 1) begin
							samples[n_smp]     = sample_t'(f[0]);
							samples[n_smp + 1] = sample_t'(f[1]);
						end
						n_smp += 2;
						cnt = cnt - 2;
					end
					if (cnt != 0) begin
						error_count++;
						$display("malformed line in vector file: %s", line);
					end
				end
			end
			$fclose(fd);
		end
		check_count("samples in vector file", n_smp, `LC_COUNT*`LC_DEPTH);
	endtask

	task automatic load_cfg(int idx, lc_cfg_t c, logic boot);
		@(posedge CLK);
		boot_up       <= boot;
		cfg_in[idx]   <= c;
		cfg_load      <= '0;
		cfg_load[idx] <= 1'b1;
		@(posedge CLK);
		cfg_load <= '0;
		// a load counts only while boot_up is high
		if (boot) begin
			model_cfg[idx]   = c;
			model_valid[idx] = 1'b1;
		end
	endtask

	task automatic write_samples();
		for (int k = 0; k < `LC_COUNT*`LC_DEPTH; k++) begin
			@(posedge CLK);
			write_go  <= (k == 0);
			sample_in <= samples[k];
			last_drive_cycle = cycle;
		end
		@(posedge CLK);
		write_go  <= 1'b0;
		sample_in <= '0;
		wait_done(1'b0, 1, 40);
		repeat (4) @(posedge CLK);
		check_count("write_done pulses", wd_count, 1);
		// the last sample is written one edge after it is driven
		check_count("write_done cycle", wd_cycle, last_drive_cycle + 1);
	endtask

	task automatic add_expected(int i, pkt_kind_e k, int a, dest_t d);
		packet_t p;
		p.kind = k;
		p.data = samples[i*`LC_DEPTH + a];
		p.dest = d;
		exp_pkt.push_back(p);
		exp_idx.push_back(i);
	endtask

	// ring order, prefetch range first, then offset up to the last address
	task automatic predict_round();
		exp_pkt.delete();
		exp_idx.delete();
		for (int i = 0; i < `LC_COUNT; i++) begin
			if (model_valid[i]) begin
				if (model_cfg[i].pf_en && model_cfg[i].pf_start <= model_cfg[i].pf_stop) begin
					for (int a = model_cfg[i].pf_start; a <= model_cfg[i].pf_stop; a++) begin
						add_expected(i, PKT_PREFETCH, a, model_cfg[i].pf_dest);
					end
				end
				for (int a = model_cfg[i].rd_offset; a < `LC_DEPTH; a++) begin
					add_expected(i, PKT_READ, a, model_cfg[i].rd_dest);
				end
			end
		end
	endtask

	task automatic read_round(string tag);
		int base;
		base = rd_count;
		predict_round();
		got_pkt.delete();
		got_idx.delete();
		@(posedge CLK);
		start <= 1'b1;
		@(posedge CLK);
		start <= 1'b0;
		wait_done(1'b1, base + 1, 400);
		repeat (4) @(posedge CLK);
		check_count({tag, " read_done pulses"}, rd_count - base, 1);
		check_count({tag, " packet count"}, got_pkt.size(), exp_pkt.size());
		for (int j = 0; j < exp_pkt.size() && j < got_pkt.size(); j++) begin
			check_count({tag, " source controller"}, got_idx[j], exp_idx[j]);
			check_kind({tag, " packet_out.kind"}, got_pkt[j].kind, exp_pkt[j].kind);
			check_packet({tag, " packet_out"}, got_pkt[j], exp_pkt[j]);
		end
		if (got_pkt.size() > 0 && last_pkt_cycle > rd_cycle) begin
			error_count++;
			$display("%s: a packet arrived after read_done", tag);
		end
	endtask

	////////////////////////////////////////////////////////////
	// test sequence
	////////////////////////////////////////////////////////////

	initial begin
		boot_up         = 1'b0;
		cfg_load        = '0;
		scenario_update = 1'b0;
		write_go        = 1'b0;
		sample_in       = '0;
		start           = 1'b0;
		for (int i = 0; i < `LC_COUNT; i++) begin
			cfg_in[i]      = '0;
			model_cfg[i]   = '0;
			model_valid[i] = 1'b0;
		end
		read_vectors();
		wait_reset();

		@(negedge CLK);
		for (int i = 0; i < `LC_COUNT; i++) begin
			check_kind("packet_out.kind after reset", packet_out[i].kind, PKT_IDLE);
		end

		// reads only, prefetch switched off in every controller
		for (int i = 0; i < `LC_COUNT; i++) begin
			lc_cfg_t c;
			c = file_cfg[i];
			c.pf_en = 1'b0;
			load_cfg(i, c, 1'b1);
		end
		@(posedge CLK);
		boot_up <= 1'b0;
		check_count("write_done before write_go", wd_count, 0);
		check_count("read_done before write_go", rd_count, 0);
		write_samples();
		read_round("reads only");

		// full configuration with prefetch ranges
		for (int i = 0; i < `LC_COUNT; i++) begin
			load_cfg(i, file_cfg[i], 1'b1);
		end
		@(posedge CLK);
		boot_up <= 1'b0;
		read_round("prefetch");

		// load outside boot_up is ignored
		load_cfg(late_idx, late_cfg, 1'b0);
		read_round("late load");

		@(posedge CLK);
		scenario_update <= 1'b1;
		@(posedge CLK);
		scenario_update <= 1'b0;
		for (int i = 0; i < `LC_COUNT; i++) begin
			model_valid[i] = 1'b0;
		end
		read_round("after scenario_update");

		end_run();
	end

endmodule

`default_nettype wire

// ==== testbench/lc_ring_vectors.txt ====
# four config lines, hex: rd_offset rd_dest pf_en pf_start pf_stop pf_dest
# then a late load line: controller rd_offset rd_dest pf_en pf_start pf_stop pf_dest
# then 64 samples, two per line, in write order
0 1 1 3 5 9
8 2 0 0 0 0
4 3 1 c f a
d 4 1 7 2 b
1 3 5 1 0 2 6
# samples
3c00c33f 3c01c33e
3c02c33d 3c03c33c
3c04c33b 3c05c33a
3c06c339 3c07c338
3c08c337 3c09c336
3c0ac335 3c0bc334
3c0cc333 3c0dc332
3c0ec331 3c0fc330
3c10c32f 3c11c32e
3c12c32d 3c13c32c
3c14c32b 3c15c32a
3c16c329 3c17c328
3c18c327 3c19c326
3c1ac325 3c1bc324
3c1cc323 3c1dc322
3c1ec321 3c1fc320
3c20c31f 3c21c31e
3c22c31d 3c23c31c
3c24c31b 3c25c31a
3c26c319 3c27c318
3c28c317 3c29c316
3c2ac315 3c2bc314
3c2cc313 3c2dc312
3c2ec311 3c2fc310
3c30c30f 3c31c30e
3c32c30d 3c33c30c
3c34c30b 3c35c30a
3c36c309 3c37c308
3c38c307 3c39c306
3c3ac305 3c3bc304
3c3cc303 3c3dc302
3c3ec301 3c3fc300

// ==== verilog/drbe_cfg.svh ====
`ifndef DRBE_CFG_SVH
`define DRBE_CFG_SVH

// ring geometry
`define LC_COUNT 4
`define LC_DEPTH 16

// sample address within one controller's memory
`define LC_ADDR_W 4

// two 16-bit words per sample
`define SAMPLE_W 32

// destination tag carried by every packet
`define DEST_W 4

`endif

// ==== verilog/drbe_ctrl_pkg.sv ====
`default_nettype none

package drbe_ctrl_pkg;

	// write token stage
	typedef enum logic [1:0] {
		WR_IDLE = 2'd0,
		WR_FILL = 2'd1,
		WR_FULL = 2'd2
	} wr_state_e;

	// read token stage
	// prefetch always runs ahead of the controller's own reads
	typedef enum logic [1:0] {
		RD_IDLE     = 2'd0,
		RD_PREFETCH = 2'd1,
		RD_READ     = 2'd2,
		RD_PASS     = 2'd3
	} rd_state_e;

endpackage

`default_nettype wire

// ==== verilog/drbe_types_pkg.sv ====
`default_nettype none

`include "drbe_cfg.svh"

package drbe_types_pkg;

	typedef logic [`SAMPLE_W-1:0]  sample_t;
	typedef logic [`LC_ADDR_W-1:0] addr_t;
	typedef logic [`DEST_W-1:0]    dest_t;

	// packet opcode, idle marks an empty slot on packet_out
	typedef enum logic [1:0] {
		PKT_IDLE     = 2'd0,
		PKT_READ     = 2'd1,
		PKT_PREFETCH = 2'd2
	} pkt_kind_e;

	// per-controller configuration from the global controller
	typedef struct packed {
		addr_t rd_offset;
		dest_t rd_dest;
		logic  pf_en;
		addr_t pf_start;
		addr_t pf_stop;
		dest_t pf_dest;
	} lc_cfg_t;

	// request from the read sequencer to the sample store
	typedef struct packed {
		pkt_kind_e kind;
		addr_t     addr;
		dest_t     dest;
	} rd_req_t;

	typedef struct packed {
		pkt_kind_e kind;
		sample_t   data;
		dest_t     dest;
	} packet_t;

endpackage

`default_nettype wire

// ==== verilog/lc_read_seq.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "drbe_cfg.svh"

module lc_read_seq import drbe_types_pkg::*, drbe_ctrl_pkg::*; (
	input  wire          CLK,
	input  wire          rst_n,
	input  wire          rd_token,
	input  wire lc_cfg_t cfg,
	input  wire          cfg_valid,
	output rd_req_t      rd_req,
	output logic         rd_boundary
);

	rd_state_e state;
	addr_t     addr_q;
	logic      pf_go;
	logic      last_rd;
	logic      last_pf;

	// empty prefetch range when start lies past stop
	assign pf_go   = cfg.pf_en && (cfg.pf_start <= cfg.pf_stop);
	assign last_pf = (addr_q == cfg.pf_stop);
	assign last_rd = (addr_q == addr_t'(`LC_DEPTH - 1));

	////////////////////////////////////////////////////////////
	// token FSM
	////////////////////////////////////////////////////////////

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			state  <= RD_IDLE;
			addr_q <= '0;
		end else begin
			case (state)
				RD_IDLE: begin
					if (rd_token) begin
						if (!cfg_valid) begin
							// nothing to send, pass the token straight on
							state <= RD_PASS;
						end else if (pf_go) begin
							state  <= RD_PREFETCH;
							addr_q <= cfg.pf_start;
						end else begin
							state  <= RD_READ;
							addr_q <= cfg.rd_offset;
						end
					end
				end
				RD_PREFETCH: begin
					if (last_pf) begin
						state  <= RD_READ;
						addr_q <= cfg.rd_offset;
					end else begin
						addr_q <= addr_q + addr_t'(1);
					end
				end
				RD_READ: begin
					if (last_rd) begin
						state <= RD_PASS;
					end else begin
						addr_q <= addr_q + addr_t'(1);
					end
				end
				RD_PASS: state <= RD_IDLE;
				default: state <= RD_IDLE;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// request and hand-off
	////////////////////////////////////////////////////////////

	always_comb begin
		rd_req.kind = PKT_IDLE;
		rd_req.addr = addr_q;
		rd_req.dest = cfg.rd_dest;
		case (state)
			RD_PREFETCH: begin
				rd_req.kind = PKT_PREFETCH;
				rd_req.dest = cfg.pf_dest;
			end
			RD_READ: rd_req.kind = PKT_READ;
			default: rd_req.kind = PKT_IDLE;
		endcase
	end

	// one cycle in RD_PASS per token
	assign rd_boundary = (state == RD_PASS);

	// a token arriving mid-round would be dropped without a hand-off
	a_token_when_idle: assert property (@(posedge CLK) disable iff (!rst_n)
		rd_token |-> (state == RD_IDLE));

endmodule

`default_nettype wire

// ==== verilog/lc_ring_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "drbe_cfg.svh"

module lc_ring_top import drbe_types_pkg::*; (
	input  wire                   CLK,
	input  wire                   rst_n,
	input  wire                   boot_up,
	input  wire [`LC_COUNT-1:0]   cfg_load,
	input  wire lc_cfg_t          cfg_in [`LC_COUNT],
	input  wire                   scenario_update,
	input  wire                   write_go,
	input  wire sample_t          sample_in,
	input  wire                   start,
	output packet_t               packet_out [`LC_COUNT],
	output wire                   write_done,
	output wire                   read_done
);

	// token chains, entry i feeds controller i
	logic [`LC_COUNT:0] wr_chain;
	logic [`LC_COUNT:0] rd_chain;

	assign wr_chain[0] = write_go;
	assign rd_chain[0] = start;

	// last hand-off leaves the ring
	assign write_done = wr_chain[`LC_COUNT];
	assign read_done  = rd_chain[`LC_COUNT];

	for (genvar i = 0; i < `LC_COUNT; i++) begin : g_lc
		local_controller u_lc (
			.CLK             (CLK),
			.rst_n           (rst_n),
			.boot_up         (boot_up),
			.cfg_load        (cfg_load[i]),
			.cfg_in          (cfg_in[i]),
			.scenario_update (scenario_update),
			.sample_in       (sample_in),
			.wr_token        (wr_chain[i]),
			.wr_boundary     (wr_chain[i+1]),
			.rd_token        (rd_chain[i]),
			.rd_boundary     (rd_chain[i+1]),
			.packet_out      (packet_out[i])
		);
	end

endmodule

`default_nettype wire

// ==== verilog/lc_sample_store.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "drbe_cfg.svh"

module lc_sample_store import drbe_types_pkg::*; (
	input  wire          CLK,
	input  wire          rst_n,
	input  wire          wr_en,
	input  wire addr_t   wr_addr,
	input  wire sample_t sample_in,
	input  wire rd_req_t rd_req,
	output packet_t      packet_out
);

	sample_t   mem [`LC_DEPTH];
	pkt_kind_e kind_q;
	sample_t   data_q;
	dest_t     dest_q;

	// write port
	always_ff @(posedge CLK) begin
		if (wr_en) begin
			mem[wr_addr] <= sample_in;
		end
	end

	////////////////////////////////////////////////////////////
	// registered read port, one cycle from request to packet
	////////////////////////////////////////////////////////////

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			kind_q <= PKT_IDLE;
		end else begin
			kind_q <= rd_req.kind;
		end
	end

	always_ff @(posedge CLK) begin
		if (rd_req.kind != PKT_IDLE) begin
			data_q <= mem[rd_req.addr];
			dest_q <= rd_req.dest;
		end
	end

	assign packet_out = '{kind: kind_q, data: data_q, dest: dest_q};

	// write ring and read ring must not overlap in one controller
	a_no_rw_clash: assert property (@(posedge CLK) disable iff (!rst_n)
		!(wr_en && (rd_req.kind != PKT_IDLE)));

endmodule

`default_nettype wire

// ==== verilog/lc_write_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "drbe_cfg.svh"

module lc_write_ctrl import drbe_types_pkg::*, drbe_ctrl_pkg::*; (
	input  wire   CLK,
	input  wire   rst_n,
	input  wire   wr_token,
	output logic  wr_en,
	output addr_t wr_addr,
	output logic  wr_boundary
);

	wr_state_e state;
	addr_t     cnt;

	// address 0 is written on the edge that sees the token
	assign wr_en   = (state == WR_FILL) || ((state == WR_IDLE) && wr_token);
	assign wr_addr = (state == WR_FILL) ? cnt : '0;

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			state       <= WR_IDLE;
			cnt         <= '0;
			wr_boundary <= 1'b0;
		end else begin
			wr_boundary <= 1'b0;
			case (state)
				WR_IDLE: begin
					if (wr_token) begin
						state <= WR_FILL;
						cnt   <= addr_t'(1);
					end
				end
				WR_FILL: begin
					cnt <= cnt + addr_t'(1);
					if (cnt == addr_t'(`LC_DEPTH - 1)) begin
						// next controller starts on the following edge
						state       <= WR_FULL;
						wr_boundary <= 1'b1;
					end
				end
				// full until reset
				WR_FULL: state <= WR_FULL;
				default: state <= WR_IDLE;
			endcase
		end
	end

	// upstream controller must not hand over while this one is filling
	a_no_token_in_fill: assert property (@(posedge CLK) disable iff (!rst_n)
		(state == WR_FILL) |-> !wr_token);

endmodule

`default_nettype wire

// ==== verilog/local_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

module local_controller import drbe_types_pkg::*; (
	input  wire          CLK,
	input  wire          rst_n,
	input  wire          boot_up,
	input  wire          cfg_load,
	input  wire lc_cfg_t cfg_in,
	input  wire          scenario_update,
	input  wire sample_t sample_in,
	input  wire          wr_token,
	output wire          wr_boundary,
	input  wire          rd_token,
	output wire          rd_boundary,
	output wire packet_t packet_out
);

	lc_cfg_t cfg_q;
	logic    cfg_valid;
	logic    wr_en;
	addr_t   wr_addr;
	rd_req_t rd_req;

	////////////////////////////////////////////////////////////
	// configuration register
	////////////////////////////////////////////////////////////

	// loads only count during boot_up
	always_ff @(posedge CLK) begin
		if (cfg_load && boot_up) begin
			cfg_q <= cfg_in;
		end
	end

	always_ff @(posedge CLK or negedge rst_n) begin
		if (!rst_n) begin
			cfg_valid <= 1'b0;
		end else if (scenario_update) begin
			cfg_valid <= 1'b0;
		end else if (cfg_load && boot_up) begin
			cfg_valid <= 1'b1;
		end
	end

	////////////////////////////////////////////////////////////
	// stages
	////////////////////////////////////////////////////////////

	lc_write_ctrl u_wr (
		.CLK         (CLK),
		.rst_n       (rst_n),
		.wr_token    (wr_token),
		.wr_en       (wr_en),
		.wr_addr     (wr_addr),
		.wr_boundary (wr_boundary)
	);

	lc_read_seq u_rd (
		.CLK         (CLK),
		.rst_n       (rst_n),
		.rd_token    (rd_token),
		.cfg         (cfg_q),
		.cfg_valid   (cfg_valid),
		.rd_req      (rd_req),
		.rd_boundary (rd_boundary)
	);

	lc_sample_store u_mem (
		.CLK        (CLK),
		.rst_n      (rst_n),
		.wr_en      (wr_en),
		.wr_addr    (wr_addr),
		.sample_in  (sample_in),
		.rd_req     (rd_req),
		.packet_out (packet_out)
	);

endmodule

`default_nettype wire
